// ==== rtl/fetch_pkg.sv ====
/*
  Shared constants and types of the fetch stage.
  Only aligned 32-bit instructions are fetched, XLEN is fixed at 32.
  FIFO_DEPTH also bounds the number of outstanding bus requests.
*/
package fetch_pkg;

  //////////////////////////////////////////////////
  // widths and addresses
  //////////////////////////////////////////////////

  localparam int unsigned XLEN = 32;

  // boot entry sits this far above the 512-byte aligned boot base
  localparam logic [XLEN-1:0] BOOT_OFFSET  = 32'h0000_0100;

  // debug module entry points
  localparam logic [XLEN-1:0] DM_HALT_ADDR = 32'h1A11_0800;
  localparam logic [XLEN-1:0] DM_EXC_ADDR  = 32'h1A11_0808;

  // buffered words, equal to the outstanding request limit
  localparam int unsigned FIFO_DEPTH = 2;
  localparam int unsigned PTR_W      = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W      = $clog2(FIFO_DEPTH + 1);

  //////////////////////////////////////////////////
  // selectors
  //////////////////////////////////////////////////

  // source of the next fetch address
  typedef enum logic [2:0] {
    PC_BOOT = 3'd0,
    PC_JUMP = 3'd1,
    PC_EXC  = 3'd2,
    PC_ERET = 3'd3,
    PC_DRET = 3'd4
  } pc_sel_e;

  // exception target mode
  typedef enum logic [1:0] {
    EXC_PC_EXC     = 2'd0,
    EXC_PC_IRQ     = 2'd1,
    EXC_PC_DBD     = 2'd2,
    EXC_PC_DBG_EXC = 2'd3
  } exc_pc_sel_e;

  //////////////////////////////////////////////////
  // bundles
  //////////////////////////////////////////////////

  typedef struct packed {
    logic       irq;
    logic [4:0] cause;
  } exc_cause_t;

  // one fetched word with its address and bus error
  typedef struct packed {
    logic [XLEN-1:0] addr;
    logic [XLEN-1:0] rdata;
    logic            err;
  } fetch_word_t;

  typedef struct packed {
    logic            req;
    logic [XLEN-1:0] addr;
  } redirect_t;

  typedef struct packed {
    logic [XLEN-1:0] mtvec;
    logic [XLEN-1:0] mepc;
    logic [XLEN-1:0] depc;
  } csr_vec_t;

endpackage

// ==== rtl/pc_select.sv ====
/*
  Next fetch address selection, purely combinational.
  Boot address bits 8..0 are ignored, mtvec bits 7..0 likewise.
  Vectored mode uses the cause code as is, the irq flag does not remap it.
*/
`timescale 1ns/1ps

module pc_select (
  input  fetch_pkg::pc_sel_e     pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e exc_pc_mux_i,
  input  fetch_pkg::exc_cause_t  exc_cause_i,
  input  logic                   pc_set_i,
  input  logic [fetch_pkg::XLEN-1:0] boot_addr_i,
  input  logic [fetch_pkg::XLEN-1:0] branch_target_i,
  input  fetch_pkg::csr_vec_t    csr_i,
  output fetch_pkg::redirect_t   redirect_o,
  output logic                   csr_mtvec_init_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0] exc_pc;
  logic [XLEN-1:0] boot_pc;
  logic [XLEN-1:0] next_pc;

  // exception target
  always_comb begin
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = {csr_i.mtvec[XLEN-1:8], 8'h00};
      // one 4-byte slot per cause code
      EXC_PC_IRQ:     exc_pc = {csr_i.mtvec[XLEN-1:8], 1'b0, exc_cause_i.cause, 2'b00};
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = {csr_i.mtvec[XLEN-1:8], 8'h00};
    endcase
  end

  // boot base keeps the upper bits only
  assign boot_pc = {boot_addr_i[XLEN-1:9], 9'h000} + BOOT_OFFSET;

  // fetch address mux
  always_comb begin
    unique case (pc_mux_i)
      PC_BOOT: next_pc = boot_pc;
      PC_JUMP: next_pc = branch_target_i;
      PC_EXC:  next_pc = exc_pc;
      // return from trap
      PC_ERET: next_pc = csr_i.mepc;
      PC_DRET: next_pc = csr_i.depc;
      default: next_pc = boot_pc;
    endcase
  end

  // bit 0 is never a valid fetch address bit
  assign redirect_o.req  = pc_set_i;
  assign redirect_o.addr = {next_pc[XLEN-1:1], 1'b0};

  // CSR file loads its mtvec reset value on the boot jump
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

endmodule

// ==== rtl/fetch_fifo.sv ====
/*
  Word buffer between bus responses and the IF-ID register.
  The caller must not push when full; slots are reserved upstream.
  Addresses are tracked here, starting at the flush address.
*/
`timescale 1ns/1ps

module fetch_fifo (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       flush_i,
  input  logic [fetch_pkg::XLEN-1:0] flush_addr_i,
  input  logic                       push_i,
  input  logic [fetch_pkg::XLEN-1:0] push_rdata_i,
  input  logic                       push_err_i,
  input  logic                       pop_i,
  output logic                       valid_o,
  output fetch_pkg::fetch_word_t     word_o,
  output logic [fetch_pkg::CNT_W-1:0] count_o
);
  import fetch_pkg::*;

  logic [XLEN-1:0]  rdata_q [FIFO_DEPTH];
  logic             err_q   [FIFO_DEPTH];
  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic [XLEN-1:0]  addr_q;
  logic             pop;

  // wrap at the depth, which need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    nxt = (ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : ptr + PTR_W'(1);
    return nxt;
  endfunction

  // nothing leaves while the buffer is being flushed
  assign valid_o = (count_q != '0) & ~flush_i;
  assign pop     = pop_i & valid_o;

  //////////////////////////////////////////////////
  // control
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
      addr_q   <= '0;
    end else if (flush_i) begin
      // drop every entry, restart address tracking
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
      addr_q   <= flush_addr_i;
    end else begin
      if (push_i) begin
        wr_ptr_q <= ptr_inc(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_inc(rd_ptr_q);
        addr_q   <= addr_q + XLEN'(4);
      end
      count_q <= count_q + CNT_W'(push_i) - CNT_W'(pop);
    end
  end

  // storage
  always_ff @(posedge clk_i) begin
    if (push_i && !flush_i) begin
      rdata_q[wr_ptr_q] <= push_rdata_i;
      err_q[wr_ptr_q]   <= push_err_i;
    end
  end

  assign word_o.addr  = addr_q;
  assign word_o.rdata = rdata_q[rd_ptr_q];
  assign word_o.err   = err_q[rd_ptr_q];
  assign count_o      = count_q;

endmodule

// ==== rtl/prefetch_buffer.sv ====
/*
  Instruction bus master with word prefetch.
  A request pending at a redirect is still completed; its response is dropped
  and the new target is requested once that request is granted.
*/
`timescale 1ns/1ps

module prefetch_buffer (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_i,
  input  fetch_pkg::redirect_t       redirect_i,
  input  logic                       ready_i,
  output logic                       valid_o,
  output fetch_pkg::fetch_word_t     word_o,
  output logic                       instr_req_o,
  output logic [fetch_pkg::XLEN-1:0] instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0] instr_rdata_i,
  input  logic                       instr_err_i,
  output logic                       busy_o
);
  import fetch_pkg::*;

  logic             active_q;
  logic             hold_q;
  logic             hold_stale_q;
  logic [XLEN-1:0]  hold_addr_q;
  logic [XLEN-1:0]  fetch_addr_q;
  logic [CNT_W-1:0] out_q;
  logic [CNT_W-1:0] disc_q;
  logic [CNT_W-1:0] fifo_count;
  logic [CNT_W:0]   slots_used;
  logic             rsp_live_q;
  logic [XLEN-1:0]  rsp_rdata_q;
  logic             rsp_err_q;
  logic             redirect;
  logic             room;
  logic             issue_new;
  logic             granted;
  logic             gnt_stale;
  logic             rsp_live;

  assign redirect = redirect_i.req;

  //////////////////////////////////////////////////
  // request side
  //////////////////////////////////////////////////

  // in flight, waiting to be pushed and buffered all hold a slot
  assign slots_used = {1'b0, out_q} + {1'b0, fifo_count} + (CNT_W + 1)'(rsp_live_q);
  assign room       = slots_used < (CNT_W + 1)'(FIFO_DEPTH);

  // no new address goes out in the redirect cycle itself
  assign issue_new = active_q & ~redirect & ~hold_q & room;

  // an ungranted request keeps its address
  assign instr_req_o  = hold_q | issue_new;
  assign instr_addr_o = hold_q ? hold_addr_q : fetch_addr_q;

  assign granted   = instr_req_o & instr_gnt_i;
  assign gnt_stale = granted & (hold_stale_q | redirect);

  // the response in a redirect cycle always belongs to an older request
  assign rsp_live = instr_rvalid_i & ~redirect & (disc_q == '0);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      active_q     <= 1'b0;
      hold_q       <= 1'b0;
      hold_stale_q <= 1'b0;
      out_q        <= '0;
      disc_q       <= '0;
      rsp_live_q   <= 1'b0;
      fetch_addr_q <= '0;
    end else begin
      // fetching starts on a redirect and stops when req_i drops
      active_q     <= redirect ? req_i : (active_q & req_i);
      hold_q       <= instr_req_o & ~instr_gnt_i;
      hold_stale_q <= instr_req_o & ~instr_gnt_i & (hold_stale_q | redirect);
      out_q        <= out_q + CNT_W'(granted) - CNT_W'(instr_rvalid_i);
      if (redirect) begin
        // everything still in flight is now stale
        disc_q <= out_q + CNT_W'(granted) - CNT_W'(instr_rvalid_i);
      end else begin
        disc_q <= disc_q + CNT_W'(gnt_stale) - CNT_W'(instr_rvalid_i & (disc_q != '0));
      end
      rsp_live_q <= rsp_live;
      if (redirect) begin
        fetch_addr_q <= redirect_i.addr;
      end else if (granted && !gnt_stale) begin
        fetch_addr_q <= fetch_addr_q + XLEN'(4);
      end
    end
  end

  // held address and registered response
  always_ff @(posedge clk_i) begin
    if (issue_new) begin
      hold_addr_q <= fetch_addr_q;
    end
    if (instr_rvalid_i) begin
      rsp_rdata_q <= instr_rdata_i;
      rsp_err_q   <= instr_err_i;
    end
  end

  //////////////////////////////////////////////////
  // buffer
  //////////////////////////////////////////////////

  fetch_fifo u_fetch_fifo (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .flush_i      (redirect),
    .flush_addr_i (redirect_i.addr),
    .push_i       (rsp_live_q),
    .push_rdata_i (rsp_rdata_q),
    .push_err_i   (rsp_err_q),
    .pop_i        (ready_i),
    .valid_o      (valid_o),
    .word_o       (word_o),
    .count_o      (fifo_count)
  );

  assign busy_o = hold_q | (out_q != '0);

endmodule

// ==== rtl/if_id_reg.sv ====
/*
  IF-ID pipeline register.
  Valid is held until explicitly cleared by the ID stage.
  A redirect in the transfer cycle squashes the incoming word.
*/
`timescale 1ns/1ps

module if_id_reg (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   valid_i,
  input  fetch_pkg::fetch_word_t word_i,
  input  logic                   id_in_ready_i,
  input  logic                   pc_set_i,
  input  logic                   instr_valid_clear_i,
  output logic                   ready_o,
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o,
  output fetch_pkg::fetch_word_t id_word_o
);

  logic transfer;
  logic valid_d;
  logic valid_q;
  logic new_q;

  // ID pulls the word, no extra stall source in IF
  assign ready_o  = id_in_ready_i;
  assign transfer = valid_i & id_in_ready_i;

  // set by an unsquashed transfer, held until cleared
  assign valid_d = (transfer & ~pc_set_i) | (valid_q & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
      new_q   <= 1'b0;
    end else begin
      valid_q <= valid_d;
      // one pulse per accepted word
      new_q   <= transfer;
    end
  end

  // word register, frozen while ID stalls
  always_ff @(posedge clk_i) begin
    if (transfer) begin
      id_word_o <= word_i;
    end
  end

  assign instr_valid_id_o = valid_q;
  assign instr_new_id_o   = new_q;

endmodule

// ==== rtl/pc_incr_check.sv ====
/*
  Sequential PC consistency check.
  Assumes every instruction is a 4-byte word.
*/
`timescale 1ns/1ps

module pc_incr_check (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   new_i,
  input  fetch_pkg::fetch_word_t id_word_i,
  input  fetch_pkg::fetch_word_t if_word_i,
  input  logic                   if_valid_i,
  input  logic                   pc_set_i,
  output logic                   pc_mismatch_alert_o
);
  import fetch_pkg::*;

  logic            seq_q;
  logic            seq_run;
  logic [XLEN-1:0] expected_pc;
  logic            mismatch;

  // a run starts with the first word in ID after a redirect
  assign seq_run     = seq_q | new_i;
  assign expected_pc = id_word_i.addr + XLEN'(4);
  assign mismatch    = if_valid_i & (if_word_i.addr != expected_pc);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      seq_q               <= 1'b0;
      pc_mismatch_alert_o <= 1'b0;
    end else begin
      // redirects and faulting words break the run
      seq_q               <= seq_run & ~pc_set_i & ~(if_valid_i & if_word_i.err);
      pc_mismatch_alert_o <= seq_run & ~pc_set_i & mismatch;
    end
  end

endmodule

// ==== rtl/fetch_stage.sv ====
/*
  Instruction fetch stage top level.
  Fetching begins with a redirect while req_i is high, usually the boot jump.
*/
`timescale 1ns/1ps

module fetch_stage (
  input  logic                       clk_i,
  input  logic                       rst_ni,
  input  logic                       req_i,
  // next PC control
  input  fetch_pkg::pc_sel_e         pc_mux_i,
  input  fetch_pkg::exc_pc_sel_e     exc_pc_mux_i,
  input  fetch_pkg::exc_cause_t      exc_cause_i,
  input  logic                       pc_set_i,
  input  logic [fetch_pkg::XLEN-1:0] boot_addr_i,
  input  logic [fetch_pkg::XLEN-1:0] branch_target_i,
  input  fetch_pkg::csr_vec_t        csr_i,
  // instruction bus
  output logic                       instr_req_o,
  output logic [fetch_pkg::XLEN-1:0] instr_addr_o,
  input  logic                       instr_gnt_i,
  input  logic                       instr_rvalid_i,
  input  logic [fetch_pkg::XLEN-1:0] instr_rdata_i,
  input  logic                       instr_err_i,
  // ID side
  input  logic                       id_in_ready_i,
  input  logic                       instr_valid_clear_i,
  output logic                       instr_valid_id_o,
  output logic                       instr_new_id_o,
  output logic [fetch_pkg::XLEN-1:0] instr_rdata_id_o,
  output logic [fetch_pkg::XLEN-1:0] pc_id_o,
  output logic                       instr_fetch_err_o,
  // status
  output logic                       csr_mtvec_init_o,
  output logic                       if_busy_o,
  output logic                       pc_mismatch_alert_o
);
  import fetch_pkg::*;

  redirect_t   redirect;
  logic        if_valid;
  logic        if_ready;
  fetch_word_t if_word;
  fetch_word_t id_word;

  pc_select u_pc_select (
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .exc_cause_i      (exc_cause_i),
    .pc_set_i         (pc_set_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_i            (csr_i),
    .redirect_o       (redirect),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  prefetch_buffer u_prefetch_buffer (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .req_i          (req_i),
    .redirect_i     (redirect),
    .ready_i        (if_ready),
    .valid_o        (if_valid),
    .word_o         (if_word),
    .instr_req_o    (instr_req_o),
    .instr_addr_o   (instr_addr_o),
    .instr_gnt_i    (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i),
    .instr_rdata_i  (instr_rdata_i),
    .instr_err_i    (instr_err_i),
    .busy_o         (if_busy_o)
  );

  if_id_reg u_if_id_reg (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .valid_i             (if_valid),
    .word_i              (if_word),
    .id_in_ready_i       (id_in_ready_i),
    .pc_set_i            (pc_set_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .ready_o             (if_ready),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .id_word_o           (id_word)
  );

  pc_incr_check u_pc_incr_check (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .new_i               (instr_new_id_o),
    .id_word_i           (id_word),
    .if_word_i           (if_word),
    .if_valid_i          (if_valid),
    .pc_set_i            (pc_set_i),
    .pc_mismatch_alert_o (pc_mismatch_alert_o)
  );

  // unpack the ID word
  assign instr_rdata_id_o  = id_word.rdata;
  assign pc_id_o           = id_word.addr;
  assign instr_fetch_err_o = id_word.err;

endmodule

// ==== dv/fetch_stage_tb.sv ====
/*
  Directed testbench of the fetch stage with an instruction memory model.
  Memory grants one cycle after a request and answers in order after 1 to 3 cycles.
  Read data is the address xor a key, ERR_ADDR answers with a bus error.
*/
`timescale 1ns/1ps

module fetch_stage_tb;
  import fetch_pkg::*;

  localparam logic [31:0] DATA_KEY     = 32'hA5A5_A5A5;
  localparam logic [31:0] ERR_ADDR     = 32'h0000_4010;
  localparam logic [31:0] BOOT_ADDR    = 32'h2000_0A5C;
  localparam logic [31:0] MTVEC        = 32'h0000_3C85;
  localparam logic [31:0] MEPC         = 32'h0000_6001;
  localparam logic [31:0] DEPC         = 32'h0000_7008;
  localparam logic [4:0]  CAUSE        = 5'd5;
  localparam int          WORD_TIMEOUT = 50;

  // expected redirect targets by the address rules
  localparam logic [31:0] BOOT_PC = (BOOT_ADDR & 32'hFFFF_FE00) + BOOT_OFFSET;
  localparam logic [31:0] EXC_PC  = MTVEC & 32'hFFFF_FF00;
  localparam logic [31:0] IRQ_PC  = EXC_PC | {25'b0, CAUSE, 2'b00};
  localparam logic [31:0] ERET_PC = MEPC & 32'hFFFF_FFFE;

  logic        clk_i;
  logic        rst_ni;
  logic        req_i;
  pc_sel_e     pc_mux_i;
  exc_pc_sel_e exc_pc_mux_i;
  exc_cause_t  exc_cause_i;
  logic        pc_set_i;
  logic [31:0] boot_addr_i;
  logic [31:0] branch_target_i;
  csr_vec_t    csr_i;
  logic        instr_req_o;
  logic [31:0] instr_addr_o;
  logic        instr_gnt_i;
  logic        instr_rvalid_i;
  logic [31:0] instr_rdata_i;
  logic        instr_err_i;
  logic        id_in_ready_i;
  logic        instr_valid_clear_i;
  logic        instr_valid_id_o;
  logic        instr_new_id_o;
  logic [31:0] instr_rdata_id_o;
  logic [31:0] pc_id_o;
  logic        instr_fetch_err_o;
  logic        csr_mtvec_init_o;
  logic        if_busy_o;
  logic        pc_mismatch_alert_o;

  int          seed = 75;
  logic [31:0] rnd_q;
  logic        bp_on;
  logic        hold_ready;
  logic [31:0] exp_pc;
  int          words_seen;
  int          error_count;
  string       test_name;
  logic [31:0] rsp_addr_q[$];
  int          rsp_due_q[$];

  fetch_stage UUT (.*);

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // memory model
  //////////////////////////////////////////////////

  initial begin : mem_model
    int          lat;
    int          due;
    int          cyc;
    int          last_due;
    logic [31:0] addr;
    instr_gnt_i    <= 1'b0;
    instr_rvalid_i <= 1'b0;
    instr_rdata_i  <= '0;
    instr_err_i    <= 1'b0;
    rnd_q          <= '0;
    cyc      = 0;
    last_due = -1;
    forever begin
      @(posedge clk_i);
      // one draw per cycle also feeds the back-pressure pattern
      rnd_q <= $random(seed);
      if (instr_req_o && instr_gnt_i) begin
        lat = 1 + int'($unsigned($random(seed)) % 3);
        due = cyc + lat - 1;
        // responses stay in order
        if (due <= last_due) begin
          due = last_due + 1;
        end
        last_due = due;
        rsp_addr_q.push_back(instr_addr_o);
        rsp_due_q.push_back(due);
        instr_gnt_i <= 1'b0;
      end else begin
        instr_gnt_i <= instr_req_o;
      end
      if (rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc) begin
        addr = rsp_addr_q.pop_front();
        void'(rsp_due_q.pop_front());
        instr_rvalid_i <= 1'b1;
        instr_rdata_i  <= addr ^ DATA_KEY;
        instr_err_i    <= (addr == ERR_ADDR);
      end else begin
        instr_rvalid_i <= 1'b0;
        instr_err_i    <= 1'b0;
      end
      cyc = cyc + 1;
    end
  end

  //////////////////////////////////////////////////
  // checking helpers
  //////////////////////////////////////////////////

  task automatic stop_run();
    error_count = error_count + 1;
    $display("Simulation failed");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic check_val(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("FAILED %s: %s expected %h actual %h", test_name, what, exp, act);
      stop_run();
    end
  endtask

  task automatic check_true(input logic cond, input string msg);
    assert (cond) else begin
      $display("ERROR in %s: %s", test_name, msg);
      stop_run();
    end
  endtask

  task automatic drive_ready();
    if (hold_ready) begin
      id_in_ready_i <= 1'b0;
    end else if (bp_on) begin
      id_in_ready_i <= rnd_q[4];
    end else begin
      id_in_ready_i <= 1'b1;
    end
  endtask

  // per-cycle checks where each new word must follow the expected stream
  task automatic observe(input logic boot_jump);
    check_val("mtvec init", 32'(boot_jump), 32'(csr_mtvec_init_o));
    check_true(!pc_mismatch_alert_o, "sequential PC alert raised");
    if (instr_new_id_o) begin
      check_val("pc", exp_pc, pc_id_o);
      check_val("rdata", exp_pc ^ DATA_KEY, instr_rdata_id_o);
      check_val("fetch error", 32'(exp_pc == ERR_ADDR), 32'(instr_fetch_err_o));
      exp_pc     = exp_pc + 32'd4;
      words_seen = words_seen + 1;
    end
  endtask

  // drive on the rising edge and look on the falling edge
  task automatic step();
    @(posedge clk_i);
    pc_set_i            <= 1'b0;
    instr_valid_clear_i <= 1'b0;
    drive_ready();
    @(negedge clk_i);
    observe(1'b0);
  endtask

  task automatic redirect(input pc_sel_e src, input exc_pc_sel_e mode,
                          input logic [31:0] jump_addr, input logic [31:0] target);
    @(posedge clk_i);
    pc_mux_i            <= src;
    exc_pc_mux_i        <= mode;
    branch_target_i     <= jump_addr;
    pc_set_i            <= 1'b1;
    instr_valid_clear_i <= 1'b0;
    drive_ready();
    @(negedge clk_i);
    // a word seen here still belongs to the old stream
    observe(src == PC_BOOT);
    exp_pc = target;
  endtask

  task automatic take_words(input int n);
    int target;
    int waited;
    target = words_seen + n;
    waited = 0;
    while (words_seen < target) begin
      step();
      waited = waited + 1;
      check_true(waited <= n * WORD_TIMEOUT, "timed out waiting for instructions");
    end
  endtask

  //////////////////////////////////////////////////
  // directed tests
  //////////////////////////////////////////////////

  task automatic test_reset();
    int i;
    test_name = "reset";
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    // nothing moves before the boot jump
    for (i = 0; i < 4; i++) begin
      step();
      check_val("req before boot", 32'd0, 32'(instr_req_o));
      check_val("valid before boot", 32'd0, 32'(instr_valid_id_o));
      check_val("new before boot", 32'd0, 32'(instr_new_id_o));
      check_val("busy before boot", 32'd0, 32'(if_busy_o));
    end
    redirect(PC_BOOT, EXC_PC_EXC, 32'd0, BOOT_PC);
    check_val("req in redirect cycle", 32'd0, 32'(instr_req_o));
    step();
    check_val("req after redirect", 32'd1, 32'(instr_req_o));
    check_val("first fetch address", BOOT_PC, instr_addr_o);
    step();
    step();
    // the first request has been granted and awaits its response
    check_val("busy while fetching", 32'd1, 32'(if_busy_o));
    take_words(1);
  endtask

  task automatic test_sequential();
    test_name = "sequential";
    take_words(16);
  endtask

  task automatic test_backpressure();
    test_name = "back-pressure";
    bp_on = 1'b1;
    take_words(24);
    bp_on = 1'b0;
  endtask

  task automatic redirect_and_fetch(input string label, input pc_sel_e src,
                                    input exc_pc_sel_e mode, input logic [31:0] jump_addr,
                                    input logic [31:0] target);
    test_name = {"redirect ", label};
    // get requests in flight first
    take_words(3);
    redirect(src, mode, jump_addr, target);
    take_words(4);
  endtask

  task automatic test_redirects();
    redirect_and_fetch("jump", PC_JUMP, EXC_PC_EXC, 32'h0000_8000, 32'h0000_8000);
    redirect_and_fetch("exc basic", PC_EXC, EXC_PC_EXC, 32'd0, EXC_PC);
    redirect_and_fetch("exc vectored", PC_EXC, EXC_PC_IRQ, 32'd0, IRQ_PC);
    redirect_and_fetch("debug halt", PC_EXC, EXC_PC_DBD, 32'd0, DM_HALT_ADDR);
    redirect_and_fetch("debug exc", PC_EXC, EXC_PC_DBG_EXC, 32'd0, DM_EXC_ADDR);
    redirect_and_fetch("mepc", PC_ERET, EXC_PC_EXC, 32'd0, ERET_PC);
    redirect_and_fetch("depc", PC_DRET, EXC_PC_EXC, 32'd0, DEPC);
  endtask

  task automatic test_bus_error();
    test_name = "bus error";
    redirect(PC_JUMP, EXC_PC_EXC, 32'h0000_4000, 32'h0000_4000);
    take_words(8);
  endtask

  task automatic test_valid_clear();
    test_name = "valid clear";
    take_words(1);
    hold_ready = 1'b1;
    step();
    check_val("valid before clear", 32'd1, 32'(instr_valid_id_o));
    @(posedge clk_i);
    instr_valid_clear_i <= 1'b1;
    id_in_ready_i       <= 1'b0;
    @(negedge clk_i);
    observe(1'b0);
    check_val("valid in clear cycle", 32'd1, 32'(instr_valid_id_o));
    step();
    check_val("valid after clear", 32'd0, 32'(instr_valid_id_o));
    step();
    check_val("valid while stalled", 32'd0, 32'(instr_valid_id_o));
    hold_ready = 1'b0;
    take_words(2);
    check_val("valid after restart", 32'd1, 32'(instr_valid_id_o));
  endtask

  initial begin
    rst_ni              <= 1'b0;
    req_i               <= 1'b1;
    pc_mux_i            <= PC_BOOT;
    exc_pc_mux_i        <= EXC_PC_EXC;
    exc_cause_i         <= '{irq: 1'b1, cause: CAUSE};
    pc_set_i            <= 1'b0;
    boot_addr_i         <= BOOT_ADDR;
    branch_target_i     <= '0;
    csr_i               <= '{mtvec: MTVEC, mepc: MEPC, depc: DEPC};
    id_in_ready_i       <= 1'b1;
    instr_valid_clear_i <= 1'b0;
    bp_on       = 1'b0;
    hold_ready  = 1'b0;
    exp_pc      = '0;
    words_seen  = 0;
    error_count = 0;
    test_reset();
    test_sequential();
    test_backpressure();
    test_redirects();
    test_bus_error();
    test_valid_clear();
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== fetch_stage.f ====
rtl/fetch_pkg.sv
rtl/pc_select.sv
rtl/fetch_fifo.sv
rtl/prefetch_buffer.sv
rtl/if_id_reg.sv
rtl/pc_incr_check.sv
rtl/fetch_stage.sv
dv/fetch_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# builds and runs the fetch stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert -f fetch_stage.f \
    --top-module fetch_stage_tb -o fetch_stage_sim; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/fetch_stage_sim 2>&1)
status=$?
printf '%s\n' "$out"
if [ "$status" -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
  exit 0
else
  exit 1
fi
